//--- psg_audio.f
+incdir+source
source/psg_audio_pkg.sv
source/psg_regs.sv
source/psg_tone_gen.sv
source/psg_mixer.sv
source/one_bit_dac.sv
source/psg_audio_top.sv
testbench/tb_psg_audio.sv

//--- Bender.yml
package:
  name: psg_audio

sources:
  - include_dirs:
      - source
    files:
      - source/psg_audio_pkg.sv
      - source/psg_regs.sv
      - source/psg_tone_gen.sv
      - source/psg_mixer.sv
      - source/one_bit_dac.sv
      - source/psg_audio_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_psg_audio.sv

//--- testbench/tb_psg_audio.sv
`timescale 1ns/1ns

`include "psg_audio_defs.svh"

module tb_psg_audio
  import psg_audio_pkg::*;
();

  // Cycle budgets per test size the watchdog
  localparam int RESET_CYCLES = 20;
  localparam int T1_CYCLES    = 100;
  localparam int T2_CYCLES    = 60;
  localparam int T3_CYCLES    = 150;
  localparam int T4_CYCLES    = 2 * 900;
  localparam int T5_CYCLES    = 2 * 16700;
  localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                + T4_CYCLES + T5_CYCLES;
  localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * 4;

  logic      sys_clk, rst_i, wr_i, rd_i;
  reg_addr_t addr_i;
  reg_data_t wdata_i, rdata_o;
  pcm_t      pcm_o;
  logic      dac_o, acc1_overflow_o, acc2_overflow_o;
  integer    seed;
  logic      ovf_watch;  // Overflow flags must stay low while set

  psg_audio_top u_psg_audio_top (
    .sys_clk         (sys_clk),
    .rst_i           (rst_i),
    .wr_i            (wr_i),
    .rd_i            (rd_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .rdata_o         (rdata_o),
    .pcm_o           (pcm_o),
    .dac_o           (dac_o),
    .acc1_overflow_o (acc1_overflow_o),
    .acc2_overflow_o (acc2_overflow_o)
  );

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s: got 0x%04h, expected 0x%04h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "register mismatch");
    end
  endtask

  task automatic check_pcm(input pcm_t got, input pcm_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s: got %0d, expected %0d", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "PCM mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  // Flags are one-cycle pulses so every cycle is looked at
  always @(negedge sys_clk) begin
    if (ovf_watch) begin
      check_bit(acc1_overflow_o, 1'b0, "acc1 overflow flag");
      check_bit(acc2_overflow_o, 1'b0, "acc2 overflow flag");
    end
  end

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(negedge sys_clk);
    wr_i    = 1'b1;
    addr_i  = addr;
    wdata_i = data;
    @(negedge sys_clk);
    wr_i    = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(negedge sys_clk);
    rd_i   = 1'b1;
    addr_i = addr;
    @(negedge sys_clk);
    rd_i   = 1'b0;
    data   = rdata_o;  // Valid one cycle after the strobe
  endtask

  // Implemented bits of each register
  function automatic reg_data_t field_mask(input reg_addr_t addr);
    case (addr)
      `REG_PERIOD0, `REG_PERIOD1, `REG_PERIOD2: return 16'h0fff;
      `REG_VOL0, `REG_VOL1, `REG_VOL2:          return 16'h000f;
      `REG_TONE_EN:                             return 16'h0007;
      default:                                  return 16'h0000;
    endcase
  endfunction

  function automatic int level_of(input volume_t vol);
    return int'(vol) << `LEVEL_SHIFT;
  endfunction

  // One audible channel with the others muted
  task automatic solo_channel(input int ch, input volume_t vol, input int period);
    write_reg(`REG_TONE_EN, '0);
    for (int i = 0; i < 3; i++) begin
      write_reg(reg_addr_t'(`REG_VOL0 + i), (i == ch) ? reg_data_t'(vol) : '0);
    end
    write_reg(reg_addr_t'(`REG_PERIOD0 + ch), reg_data_t'(period));
    write_reg(`REG_TONE_EN, reg_data_t'(1 << ch));
    repeat (2) @(negedge sys_clk);  // Enable reaches pcm_o
  endtask

  task automatic count_hold(input int limit, output int n);
    pcm_t start;
    start = pcm_o;
    n = 0;
    do begin
      @(negedge sys_clk);
      n++;
    end while (pcm_o == start && n < limit);
  endtask

  task automatic reset_and_readback();
    reg_data_t data;
    reg_data_t rd;
    for (int a = 0; a < 8; a++) begin
      read_reg(reg_addr_t'(a), rd);
      check_data(rd, '0, $sformatf("reset value of address %0d", a));
    end
    for (int a = 0; a < 8; a++) begin
      data = reg_data_t'($random(seed));
      write_reg(reg_addr_t'(a), data);
      read_reg(reg_addr_t'(a), rd);
      check_data(rd, data & field_mask(reg_addr_t'(a)), $sformatf("read-back of address %0d", a));
    end
  endtask

  // Sets random volumes with every tone off and returns the expected PCM
  task automatic set_dc_volumes(output int expected);
    volume_t vol;
    write_reg(`REG_TONE_EN, '0);
    expected = 0;
    for (int ch = 0; ch < 3; ch++) begin
      vol = volume_t'($random(seed));
      write_reg(reg_addr_t'(`REG_VOL0 + ch), reg_data_t'(vol));
      expected += level_of(vol);
    end
    @(negedge sys_clk);
    check_pcm(pcm_o, pcm_t'(expected), "sum of constant levels");
  endtask

  task automatic constant_levels();
    int expected;
    repeat (4) set_dc_volumes(expected);
  endtask

  task automatic period_zero_hold();
    int      ch;
    volume_t vol;
    ch  = {$random(seed)} % 3;
    vol = volume_t'(1 + {$random(seed)} % 15);
    solo_channel(ch, vol, 0);
    repeat (100) begin
      @(negedge sys_clk);
      check_pcm(pcm_o, pcm_t'(level_of(vol)), $sformatf("channel %0d with period 0", ch));
    end
  endtask

  task automatic tone_half_period();
    int      ch, period, n, exp;
    volume_t vol;
    pcm_t    prev;
    ch     = {$random(seed)} % 3;
    period = 1 + {$random(seed)} % 20;
    vol    = volume_t'(1 + {$random(seed)} % 15);
    solo_channel(ch, vol, period);
    prev = pcm_o;
    count_hold(period * `PSG_PRESCALE + 16, n);
    check_bit(pcm_o != prev, 1'b1, "pcm_o toggles within one half-period");
    exp = (pcm_o < 0) ? -level_of(vol) : level_of(vol);
    for (int h = 0; h < 4; h++) begin
      check_pcm(pcm_o, pcm_t'(exp), $sformatf("level in half-period %0d", h));
      count_hold(period * `PSG_PRESCALE + 16, n);
      check_bit(n == period * `PSG_PRESCALE, 1'b1,
                $sformatf("half-period held %0d cycles for P=%0d", n, period));
      exp = -exp;
    end
    check_pcm(pcm_o, pcm_t'(exp), "level after the last half-period");
  endtask

  task automatic dac_density();
    int  expected, ones;
    real frac, target;
    set_dc_volumes(expected);
    repeat (64 * `DAC_CLK_DIV) @(negedge sys_clk);  // Loop settles on the new input
    ones = 0;
    repeat (4096) begin
      repeat (`DAC_CLK_DIV) @(negedge sys_clk);
      if (dac_o) ones++;
    end
    frac   = ones / 4096.0;
    target = (expected + 32768) / 65536.0;
    check_bit((frac - target <= 0.01) && (target - frac <= 0.01), 1'b1,
              $sformatf("DAC density %0d/4096 for PCM %0d", ones, expected));
  endtask

  initial begin
    seed      = 62995;
    rst_i     = 1'b1;
    wr_i      = 1'b0;
    rd_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    ovf_watch = 1'b0;
    repeat (10) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_i = 1'b0;
    reset_and_readback();
    ovf_watch = 1'b1;
    constant_levels();
    period_zero_hold();
    repeat (2) tone_half_period();
    repeat (2) dac_density();
    ovf_watch = 1'b0;
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- source/psg_audio_top.sv
`timescale 1ns/1ns
`default_nettype none

module psg_audio_top
  import psg_audio_pkg::*;
(
  input  logic      sys_clk,
  input  logic      rst_i,
  // Host register port
  input  logic      wr_i,
  input  logic      rd_i,
  input  reg_addr_t addr_i,
  input  reg_data_t wdata_i,
  output reg_data_t rdata_o,
  // Audio
  output pcm_t      pcm_o,
  output logic      dac_o,
  output logic      acc1_overflow_o,
  output logic      acc2_overflow_o
);

  psg_cfg_t   cfg;
  logic [2:0] period_wr;
  logic [2:0] phase;
  pcm_t       pcm;

  psg_regs u_psg_regs (
    .sys_clk     (sys_clk),
    .rst_i       (rst_i),
    .wr_i        (wr_i),
    .rd_i        (rd_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .rdata_o     (rdata_o),
    .cfg_o       (cfg),
    .period_wr_o (period_wr)
  );

  psg_tone_gen u_psg_tone_gen (
    .sys_clk     (sys_clk),
    .rst_i       (rst_i),
    .cfg_i       (cfg),
    .period_wr_i (period_wr),
    .phase_o     (phase)
  );

  psg_mixer u_psg_mixer (
    .sys_clk (sys_clk),
    .rst_i   (rst_i),
    .cfg_i   (cfg),
    .phase_i (phase),
    .pcm_o   (pcm)
  );

  // Modulated at a quarter of sys_clk
  one_bit_dac u_one_bit_dac (
    .sys_clk         (sys_clk),
    .rst_i           (rst_i),
    .pcm_i           (pcm),
    .dac_o           (dac_o),
    .acc1_overflow_o (acc1_overflow_o),
    .acc2_overflow_o (acc2_overflow_o)
  );

  assign pcm_o = pcm;

endmodule

`default_nettype wire

//--- source/one_bit_dac.sv
`timescale 1ns/1ns
`default_nettype none

`include "psg_audio_defs.svh"

module one_bit_dac
  import psg_audio_pkg::*;
(
  input  logic sys_clk,
  input  logic rst_i,
  input  pcm_t pcm_i,
  output logic dac_o,
  output logic acc1_overflow_o,
  output logic acc2_overflow_o
);

  localparam int DIV_W      = $clog2(`DAC_CLK_DIV);
  localparam int ACC_W      = 24;       // 8 guard bits above the PCM range
  localparam int SAFE_W     = 23;       // Magnitude below 2**22 counts as safe
  localparam int FULL_SCALE = 32768;
  localparam int IN_LIMIT   = 30000;

  typedef logic signed [ACC_W-1:0] acc_t;

  logic [DIV_W-1:0] div_q;
  logic             clk_en;
  acc_t             in_ext, fb;
  acc_t             acc1_q, acc2_q;
  acc_t             acc1_d, acc2_d;
  logic             dac_q;
  logic             ovf1_q, ovf2_q;
  logic             in_range;
  logic             in_range_q;         // Input has stayed in range since reset

  function automatic logic is_safe(acc_t x);
    return (x[ACC_W-1:SAFE_W-1] == '0) || (x[ACC_W-1:SAFE_W-1] == '1);
  endfunction

  assign clk_en = (div_q == DIV_W'(`DAC_CLK_DIV - 1));

  always_ff @(posedge sys_clk) begin
    if (rst_i || clk_en) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  // Second-order loop, output bit picks the fed-back full scale
  assign in_ext = acc_t'(pcm_i);
  assign fb     = dac_q ? acc_t'(FULL_SCALE) : acc_t'(-FULL_SCALE);
  assign acc1_d = acc1_q + in_ext - fb;
  assign acc2_d = acc2_q + acc1_d - fb;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      acc1_q <= '0;
      acc2_q <= '0;
      dac_q  <= 1'b0;
      ovf1_q <= 1'b0;
      ovf2_q <= 1'b0;
    end else begin
      ovf1_q <= 1'b0;
      ovf2_q <= 1'b0;
      if (clk_en) begin
        acc1_q <= acc1_d;
        acc2_q <= acc2_d;
        dac_q  <= (acc2_d > 0);  // Quantize the new second integrator
        ovf1_q <= !is_safe(acc1_d);
        ovf2_q <= !is_safe(acc2_d);
      end
    end
  end

  assign in_range = (pcm_i >= -IN_LIMIT) && (pcm_i <= IN_LIMIT);

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      in_range_q <= 1'b1;
    end else begin
      in_range_q <= in_range_q && in_range;
    end
  end

  assign dac_o           = dac_q;
  assign acc1_overflow_o = ovf1_q;
  assign acc2_overflow_o = ovf2_q;

  // Loop stays bounded for inputs that never left the +/-30000 band
  a_no_overflow : assert property (
    @(posedge sys_clk) disable iff (rst_i)
    (in_range_q && in_range) |=> !(ovf1_q || ovf2_q)
  );

endmodule

`default_nettype wire

//--- source/psg_mixer.sv
`timescale 1ns/1ns
`default_nettype none

`include "psg_audio_defs.svh"

module psg_mixer
  import psg_audio_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_i,
  input  psg_cfg_t   cfg_i,
  input  logic [2:0] phase_i,
  output pcm_t       pcm_o
);

  pcm_t level [3];  // Per-channel amplitude from the volume
  pcm_t sum_d;
  pcm_t pcm_q;

  // Disabled tones contribute a DC level.
  // Enabled tones swing between plus and minus the level
  always_comb begin
    sum_d = '0;
    for (int ch = 0; ch < 3; ch++) begin
      level[ch] = pcm_t'(cfg_i.volume[ch]) <<< `LEVEL_SHIFT;
      if (cfg_i.tone_en[ch] && !phase_i[ch]) begin
        sum_d = sum_d - level[ch];  // Low half of the square
      end else begin
        sum_d = sum_d + level[ch];
      end
    end
  end

  // Three full-scale levels sum to 23040, no saturation needed
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      pcm_q <= '0;
    end else begin
      pcm_q <= sum_d;
    end
  end

  assign pcm_o = pcm_q;

endmodule

`default_nettype wire

//--- source/psg_tone_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "psg_audio_defs.svh"

module psg_tone_gen
  import psg_audio_pkg::*;
(
  input  logic       sys_clk,
  input  logic       rst_i,
  input  psg_cfg_t   cfg_i,
  input  logic [2:0] period_wr_i,
  output logic [2:0] phase_o
);

  localparam int PRESC_W = $clog2(`PSG_PRESCALE);

  logic [PRESC_W-1:0] presc_q;
  logic               tick;
  tone_period_t [2:0] cnt_q;    // Ticks left in the current half-period
  logic [2:0]         phase_q;

  assign tick = (presc_q == PRESC_W'(`PSG_PRESCALE - 1));

  // Shared prescaler
  always_ff @(posedge sys_clk) begin
    if (rst_i || tick) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      cnt_q   <= '0;
      phase_q <= '1;
    end else begin
      for (int ch = 0; ch < 3; ch++) begin
        if (period_wr_i[ch]) begin
          cnt_q[ch]   <= cfg_i.period[ch];  // Restart with the new period
          phase_q[ch] <= 1'b1;
        end else if (cfg_i.period[ch] == '0) begin
          phase_q[ch] <= 1'b1;              // Period 0 means no toggling
        end else if (tick) begin
          if (cnt_q[ch] <= tone_period_t'(1)) begin
            cnt_q[ch]   <= cfg_i.period[ch];
            phase_q[ch] <= ~phase_q[ch];
          end else begin
            cnt_q[ch] <= cnt_q[ch] - 1'b1;
          end
        end
      end
    end
  end

  assign phase_o = phase_q;

  // Phases move only on prescaler ticks, or on a period restart
  a_phase_on_tick : assert property (
    @(posedge sys_clk) disable iff (rst_i)
    (((phase_q ^ $past(phase_q)) & ~$past(period_wr_i)) != '0) |-> $past(tick)
  );

endmodule

`default_nettype wire

//--- source/psg_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "psg_audio_defs.svh"

module psg_regs
  import psg_audio_pkg::*;
(
  input  logic      sys_clk,
  input  logic      rst_i,
  input  logic      wr_i,
  input  logic      rd_i,
  input  reg_addr_t addr_i,
  input  reg_data_t wdata_i,
  output reg_data_t rdata_o,
  output psg_cfg_t  cfg_o,
  output logic [2:0] period_wr_o
);

  psg_cfg_t   cfg_q;
  reg_data_t  rdata_q;
  logic [2:0] period_wr_q;  // Restarts the matching tone counter

  // Write side, fields take the low bits of the write data
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      cfg_q       <= '0;
      period_wr_q <= '0;
    end else begin
      period_wr_q <= '0;
      if (wr_i) begin
        case (addr_i)
          `REG_PERIOD0: begin
            cfg_q.period[0] <= tone_period_t'(wdata_i);
            period_wr_q[0]  <= 1'b1;
          end
          `REG_PERIOD1: begin
            cfg_q.period[1] <= tone_period_t'(wdata_i);
            period_wr_q[1]  <= 1'b1;
          end
          `REG_PERIOD2: begin
            cfg_q.period[2] <= tone_period_t'(wdata_i);
            period_wr_q[2]  <= 1'b1;
          end
          `REG_VOL0:    cfg_q.volume[0] <= volume_t'(wdata_i);
          `REG_VOL1:    cfg_q.volume[1] <= volume_t'(wdata_i);
          `REG_VOL2:    cfg_q.volume[2] <= volume_t'(wdata_i);
          `REG_TONE_EN: cfg_q.tone_en   <= wdata_i[2:0];
          default: ;                    // Unmapped, write ignored
        endcase
      end
    end
  end

  // Read side, data held until the next read strobe
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      rdata_q <= '0;
    end else if (rd_i) begin
      case (addr_i)
        `REG_PERIOD0: rdata_q <= reg_data_t'(cfg_q.period[0]);
        `REG_PERIOD1: rdata_q <= reg_data_t'(cfg_q.period[1]);
        `REG_PERIOD2: rdata_q <= reg_data_t'(cfg_q.period[2]);
        `REG_VOL0:    rdata_q <= reg_data_t'(cfg_q.volume[0]);
        `REG_VOL1:    rdata_q <= reg_data_t'(cfg_q.volume[1]);
        `REG_VOL2:    rdata_q <= reg_data_t'(cfg_q.volume[2]);
        `REG_TONE_EN: rdata_q <= reg_data_t'(cfg_q.tone_en);
        default:      rdata_q <= '0;
      endcase
    end
  end

  assign cfg_o       = cfg_q;
  assign rdata_o     = rdata_q;
  assign period_wr_o = period_wr_q;

  // Host must not issue a read and a write together
  a_no_wr_rd_overlap : assert property (
    @(posedge sys_clk) disable iff (rst_i) !(wr_i && rd_i)
  );

endmodule

`default_nettype wire

//--- source/psg_audio_pkg.sv
package psg_audio_pkg;

  // Signed PCM sample as seen by the DAC
  typedef logic signed [15:0] pcm_t;

  // Tone half-period in prescaler ticks
  typedef logic [11:0] tone_period_t;

  typedef logic [3:0] volume_t;     // Channel amplitude step

  // Host register port
  typedef logic [2:0]  reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // Settings shared by the tone generator and the mixer.
  // Channel n sits at index n of each field.
  typedef struct packed {
    tone_period_t [2:0] period;
    volume_t      [2:0] volume;
    logic         [2:0] tone_en;
  } psg_cfg_t;

endpackage

//--- source/psg_audio_defs.svh
`ifndef PSG_AUDIO_DEFS_SVH
`define PSG_AUDIO_DEFS_SVH

// Register map, one 16-bit word per address
`define REG_PERIOD0   3'd0
`define REG_PERIOD1   3'd1
`define REG_PERIOD2   3'd2
`define REG_VOL0      3'd3
`define REG_VOL1      3'd4
`define REG_VOL2      3'd5
`define REG_TONE_EN   3'd6  // Address 7 is unmapped, reads as zero

// Tone timing
`define PSG_PRESCALE  8     // sys_clk cycles per prescaler tick

// Volume to level, 15 << 9 = 7680 per channel
`define LEVEL_SHIFT   9

`define DAC_CLK_DIV   4     // sys_clk cycles per DAC update

`endif
